// ==== dtpu_params.svh ====
`ifndef DTPU_PARAMS_SVH
`define DTPU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Array geometry
////////////////////////////////////////////////////////////////////////////

// Weight matrix rows, one output sum each
`define DTPU_ROWS 3
// Matrix columns, one input element each
`define DTPU_COLS 3

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Widest operand, one nibble
`define DTPU_MAC_W 4
// Signed row sum
`define DTPU_ACC_W 16
// FIFO and weight memory word
`define DTPU_WORD_W 64
// CSR memory is byte wide
`define DTPU_CSR_W 8
// Both memory address buses
`define DTPU_ADDR_W 32

`endif

// ==== dtpu_pkg.sv ====
`default_nettype none

`include "dtpu_params.svh"

package dtpu_pkg;

  // Operand precision, decoded from CSR byte 0
  typedef enum logic [0:0] {
    PREC_INT4 = 1'b0,
    PREC_INT2 = 1'b1
  } precision_t;

  // Control FSM states, also seen on state_o
  typedef enum logic [3:0] {
    S_IDLE  = 4'd0,
    S_CFG   = 4'd1,
    S_WLOAD = 4'd2,
    S_WCAP  = 4'd3,
    S_READ  = 4'd4,
    S_CALC  = 4'd5,
    S_WRITE = 4'd6,
    S_DONE  = 4'd7
  } cu_state_t;

  // FIFO word or weight word
  typedef logic [`DTPU_WORD_W-1:0] word_t;
  // One row sum
  typedef logic signed [`DTPU_ACC_W-1:0] acc_t;
  typedef logic [`DTPU_CSR_W-1:0] csr_byte_t;
  typedef logic [`DTPU_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== dtpu_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Configuration bus, CSR block to control unit
////////////////////////////////////////////////////////////////////////////

interface cfg_if;
  import dtpu_pkg::*;

  // Fetch request from the FSM
  logic       fetch;
  // One cycle pulse once byte 2 is in
  logic       cfg_valid;
  precision_t prec;
  csr_byte_t  vec_count;
  addr_t      w_addr;

  modport regs (input fetch, output cfg_valid, prec, vec_count, w_addr);
  modport ctrl (output fetch, input cfg_valid, prec, vec_count, w_addr);
endinterface

////////////////////////////////////////////////////////////////////////////
// Matrix unit bus, strobes from the FSM, data from the top level
////////////////////////////////////////////////////////////////////////////

interface mxu_if;
  import dtpu_pkg::*;

  logic       w_load;
  logic       x_load;
  logic       calc;
  precision_t prec;
  // Raw weight memory data
  word_t      weight;
  // Raw input FIFO head
  word_t      x_in;
  // Registered result word
  word_t      y;

  modport ctrl (output w_load, x_load, calc, prec);
  modport array (input w_load, x_load, calc, prec, weight, x_in, output y);
endinterface

`default_nettype wire

// ==== csr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regs (
  input  logic                clk,
  input  logic                aresetn,
  output logic                csr_ce_o,
  output dtpu_pkg::addr_t     csr_address_o,
  input  dtpu_pkg::csr_byte_t csr_dout_i,
  cfg_if.regs                 cfg
);
  import dtpu_pkg::*;

  // Last CSR byte index
  localparam logic [1:0] LAST_IDX = 2'd2;

  // Issue side
  logic       busy_q;
  logic [1:0] idx_q;
  // Return side, one cycle behind
  logic       rd_q;
  logic [1:0] rd_idx_q;

  // Held configuration
  precision_t prec_q;
  csr_byte_t  vec_q;
  addr_t      w_addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      busy_q   <= 1'b0;
      idx_q    <= '0;
      rd_q     <= 1'b0;
      rd_idx_q <= '0;
    end else begin
      // Memory answers one cycle after ce
      rd_q     <= busy_q;
      rd_idx_q <= idx_q;
      if (cfg.fetch) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (busy_q) begin
        if (idx_q == LAST_IDX) begin
          busy_q <= 1'b0;
          idx_q  <= '0;
        end else begin
          idx_q <= idx_q + 2'd1;
        end
      end
    end
  end

  assign csr_ce_o      = busy_q;
  assign csr_address_o = addr_t'(idx_q);

  ////////////////////////////////////////////////////////////////////////////
  // Byte capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      prec_q   <= PREC_INT4;
      vec_q    <= '0;
      w_addr_q <= '0;
    end else if (rd_q) begin
      case (rd_idx_q)
        // Only a 1 selects INT2
        2'd0: prec_q <= (csr_dout_i == csr_byte_t'(1)) ? PREC_INT2 : PREC_INT4;
        2'd1: vec_q <= csr_dout_i;
        default: w_addr_q <= addr_t'(csr_dout_i);
      endcase
    end
  end

  // Byte 2 lands on the same edge the FSM leaves S_CFG
  assign cfg.cfg_valid = rd_q && (rd_idx_q == LAST_IDX);
  assign cfg.prec      = prec_q;
  assign cfg.vec_count = vec_q;
  assign cfg.w_addr    = w_addr_q;

  // FSM must wait for cfg_valid before a new fetch
  a_fetch_idle: assert property (@(posedge clk) disable iff (!aresetn)
    cfg.fetch |-> !busy_q && !rd_q)
    else $error("CSR fetch raised during a fetch");

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic                clk,
  input  logic                aresetn,
  input  logic                enable_i,
  // Host control port
  input  logic                cs_start_i,
  input  logic                cs_continue_i,
  output logic                cs_ready_o,
  output logic                cs_done_o,
  output logic                cs_idle_o,
  output dtpu_pkg::cu_state_t state_o,
  // Weight memory
  output logic                wm_ce_o,
  output dtpu_pkg::addr_t     wm_address_o,
  // FIFOs
  input  logic                infifo_is_empty_i,
  output logic                infifo_read_o,
  input  logic                outfifo_is_full_i,
  output logic                outfifo_write_o,
  cfg_if.ctrl                 cfg,
  mxu_if.ctrl                 mxu
);
  import dtpu_pkg::*;

  cu_state_t state_q;
  cu_state_t state_nx;
  // Vectors still to write
  csr_byte_t vec_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // State and counter registers, frozen while enable_i is low
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state_q   <= S_IDLE;
      vec_cnt_q <= '0;
    end else if (enable_i) begin
      state_q <= state_nx;
      // Config bytes are settled by S_WLOAD
      if (state_q == S_WLOAD) begin
        vec_cnt_q <= cfg.vec_count;
      end else if (outfifo_write_o) begin
        vec_cnt_q <= vec_cnt_q - csr_byte_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nx        = state_q;
    cs_ready_o      = 1'b0;
    cfg.fetch       = 1'b0;
    wm_ce_o         = 1'b0;
    mxu.w_load      = 1'b0;
    mxu.x_load      = 1'b0;
    mxu.calc        = 1'b0;
    infifo_read_o   = 1'b0;
    outfifo_write_o = 1'b0;
    case (state_q)
      S_IDLE: begin
        // Start only looked at here
        if (cs_start_i) begin
          state_nx   = S_CFG;
          cs_ready_o = enable_i;
          cfg.fetch  = enable_i;
        end
      end
      S_CFG: begin
        if (cfg.cfg_valid) begin
          state_nx = S_WLOAD;
        end
      end
      S_WLOAD: begin
        wm_ce_o  = enable_i;
        state_nx = S_WCAP;
      end
      S_WCAP: begin
        // Weight word is on wm_dout now
        mxu.w_load = enable_i;
        state_nx   = (vec_cnt_q == '0) ? S_DONE : S_READ;
      end
      S_READ: begin
        // FWFT head is valid while not empty
        if (!infifo_is_empty_i) begin
          infifo_read_o = enable_i;
          mxu.x_load    = enable_i;
          state_nx      = S_CALC;
        end
      end
      S_CALC: begin
        mxu.calc = enable_i;
        state_nx = S_WRITE;
      end
      S_WRITE: begin
        // Result held in y while full
        if (!outfifo_is_full_i) begin
          outfifo_write_o = enable_i;
          state_nx        = (vec_cnt_q == csr_byte_t'(1)) ? S_DONE : S_READ;
        end
      end
      S_DONE: begin
        if (cs_continue_i) begin
          state_nx = S_IDLE;
        end
      end
      default: state_nx = S_IDLE;
    endcase
  end

  // Levels straight from the registered state
  assign cs_idle_o    = (state_q == S_IDLE);
  assign cs_done_o    = (state_q == S_DONE);
  assign state_o      = state_q;
  assign wm_address_o = cfg.w_addr;
  assign mxu.prec     = cfg.prec;

  // FIFO strobes against their blocking levels
  a_no_read_empty: assert property (@(posedge clk) disable iff (!aresetn)
    infifo_read_o |-> !infifo_is_empty_i)
    else $error("input FIFO read while empty");

  a_no_write_full: assert property (@(posedge clk) disable iff (!aresetn)
    outfifo_write_o |-> !outfifo_is_full_i)
    else $error("output FIFO written while full");

endmodule

`default_nettype wire

// ==== mac_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_params.svh"

module mac_cell (
  input  dtpu_pkg::precision_t    prec_i,
  input  logic [`DTPU_MAC_W-1:0]  w_i,
  input  logic [`DTPU_MAC_W-1:0]  x_i,
  input  dtpu_pkg::acc_t          acc_i,
  output dtpu_pkg::acc_t          acc_o
);
  import dtpu_pkg::*;

  // Operands after precision select
  logic signed [`DTPU_MAC_W-1:0]   w_s;
  logic signed [`DTPU_MAC_W-1:0]   x_s;
  logic signed [2*`DTPU_MAC_W-1:0] prod;

  always_comb begin
    if (prec_i == PREC_INT2) begin
      // Low two bits only, bit 1 is the sign
      w_s = {{(`DTPU_MAC_W-2){w_i[1]}}, w_i[1:0]};
      x_s = {{(`DTPU_MAC_W-2){x_i[1]}}, x_i[1:0]};
    end else begin
      // Full signed nibble
      w_s = w_i;
      x_s = x_i;
    end
  end

  // Signed 4x4 fits in 8 bits
  assign prod = w_s * x_s;

  // Sign extend up to the row sum width
  assign acc_o = acc_i + {{(`DTPU_ACC_W-2*`DTPU_MAC_W){prod[2*`DTPU_MAC_W-1]}}, prod};

endmodule

`default_nettype wire

// ==== mxu_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_params.svh"

module mxu_array (
  input  logic clk,
  input  logic aresetn,
  mxu_if.array mxu
);
  import dtpu_pkg::*;

  // Operand registers
  word_t w_q;
  word_t x_q;
  // Result word
  word_t y_q;
  word_t y_nx;

  // Partial sums, column 0 is the zero seed
  acc_t acc [`DTPU_ROWS][`DTPU_COLS+1];

  ////////////////////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (mxu.w_load) begin
      w_q <= mxu.weight;
    end
    if (mxu.x_load) begin
      x_q <= mxu.x_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // MAC chains, one per row
  ////////////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `DTPU_ROWS; r++) begin : g_row
    assign acc[r][0] = '0;
    for (genvar c = 0; c < `DTPU_COLS; c++) begin : g_col
      // W[r][c] in nibble 3r+c, x[c] in nibble c
      mac_cell i_mac (
        .prec_i (mxu.prec),
        .w_i    (w_q[(r*`DTPU_COLS+c)*`DTPU_MAC_W +: `DTPU_MAC_W]),
        .x_i    (x_q[c*`DTPU_MAC_W +: `DTPU_MAC_W]),
        .acc_i  (acc[r][c]),
        .acc_o  (acc[r][c+1])
      );
    end
  end

  // Row r to bits 16r+15..16r, top bits zero
  always_comb begin
    y_nx = '0;
    for (int r = 0; r < `DTPU_ROWS; r++) begin
      y_nx[r*`DTPU_ACC_W +: `DTPU_ACC_W] = acc[r][`DTPU_COLS];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      y_q <= '0;
    end else if (mxu.calc) begin
      y_q <= y_nx;
    end
  end

  // Held through output back-pressure
  assign mxu.y = y_q;

endmodule

`default_nettype wire

// ==== dtpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtpu_core (
  input  logic                clk,
  input  logic                aresetn,
  input  logic                enable_i,
  // CSR memory, read only
  output logic                csr_ce_o,
  output dtpu_pkg::addr_t     csr_address_o,
  input  dtpu_pkg::csr_byte_t csr_dout_i,
  // Weight memory, read only
  output logic                wm_ce_o,
  output dtpu_pkg::addr_t     wm_address_o,
  input  dtpu_pkg::word_t     wm_dout_i,
  // Input FIFO, first word fall through
  input  logic                infifo_is_empty_i,
  input  dtpu_pkg::word_t     infifo_dout_i,
  output logic                infifo_read_o,
  // Output FIFO
  input  logic                outfifo_is_full_i,
  output dtpu_pkg::word_t     outfifo_din_o,
  output logic                outfifo_write_o,
  // Host control port
  input  logic                cs_start_i,
  input  logic                cs_continue_i,
  output logic                cs_ready_o,
  output logic                cs_done_o,
  output logic                cs_idle_o,
  output dtpu_pkg::cu_state_t state_o
);

  cfg_if cfg_bus ();
  mxu_if mxu_bus ();

  // Memory and FIFO data go straight to the array registers
  assign mxu_bus.weight = wm_dout_i;
  assign mxu_bus.x_in   = infifo_dout_i;
  assign outfifo_din_o  = mxu_bus.y;

  ////////////////////////////////////////////////////////////////////////////
  // CSR fetch, FSM and matrix unit
  ////////////////////////////////////////////////////////////////////////////

  csr_regs i_csr (
    .clk           (clk),
    .aresetn       (aresetn),
    .csr_ce_o      (csr_ce_o),
    .csr_address_o (csr_address_o),
    .csr_dout_i    (csr_dout_i),
    .cfg           (cfg_bus.regs)
  );

  control_unit i_cu (
    .clk               (clk),
    .aresetn           (aresetn),
    .enable_i          (enable_i),
    .cs_start_i        (cs_start_i),
    .cs_continue_i     (cs_continue_i),
    .cs_ready_o        (cs_ready_o),
    .cs_done_o         (cs_done_o),
    .cs_idle_o         (cs_idle_o),
    .state_o           (state_o),
    .wm_ce_o           (wm_ce_o),
    .wm_address_o      (wm_address_o),
    .infifo_is_empty_i (infifo_is_empty_i),
    .infifo_read_o     (infifo_read_o),
    .outfifo_is_full_i (outfifo_is_full_i),
    .outfifo_write_o   (outfifo_write_o),
    .cfg               (cfg_bus.ctrl),
    .mxu               (mxu_bus.ctrl)
  );

  mxu_array i_mxu (
    .clk     (clk),
    .aresetn (aresetn),
    .mxu     (mxu_bus.array)
  );

endmodule

`default_nettype wire

// ==== dtpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtpu_checker (
  input  logic                clk,
  input  logic                aresetn,
  input  logic                enable_i,
  input  logic                csr_ce_o,
  input  dtpu_pkg::addr_t     csr_address_o,
  input  logic                wm_ce_o,
  input  dtpu_pkg::addr_t     wm_address_o,
  input  logic                infifo_is_empty_i,
  input  dtpu_pkg::word_t     infifo_dout_i,
  input  logic                infifo_read_o,
  input  logic                outfifo_is_full_i,
  input  dtpu_pkg::word_t     outfifo_din_o,
  input  logic                outfifo_write_o,
  input  logic                cs_start_i,
  input  logic                cs_continue_i,
  input  logic                cs_ready_o,
  input  logic                cs_done_o,
  input  logic                cs_idle_o,
  input  dtpu_pkg::cu_state_t state_o,
  // Configuration of the current run
  input  logic [7:0]          exp_prec_i,
  input  logic [7:0]          exp_count_i,
  input  logic [7:0]          exp_waddr_i,
  input  dtpu_pkg::word_t     exp_weight_i,
  output int                  data_errs_o,
  output int                  ctrl_errs_o,
  output int                  runs_o,
  output int                  starts_o
);
  import dtpu_pkg::*;

  // Input words taken but not yet answered
  word_t in_q [$];
  word_t x_word;
  word_t y_exp;
  int    data_errs = 0;
  int    ctrl_errs = 0;
  int    runs = 0;
  int    starts = 0;
  int    out_cnt;
  int    csr_idx;
  logic  run_open;
  logic  first_cycle;
  logic  prev_done;
  logic  prev_cont;
  logic  prev_en;
  // Control port model
  logic  idle_exp;
  logic  ready_exp;

  assign data_errs_o = data_errs;
  assign ctrl_errs_o = ctrl_errs;
  assign runs_o      = runs;
  assign starts_o    = starts;

  // Signed value of one operand nibble
  function automatic int operand(input logic [3:0] nib, input logic int2);
    int v;
    if (int2) begin
      v = int'(nib[1:0]);
      if (nib[1]) v = v - 4;
    end else begin
      v = int'(nib);
      if (nib[3]) v = v - 16;
    end
    return v;
  endfunction

  // Row r is the sum of W[r][j] * x[j], low 16 bits kept
  function automatic word_t predict(input logic int2, input word_t w, input word_t x);
    word_t y;
    int    sum;
    y = '0;
    for (int r = 0; r < 3; r++) begin
      sum = 0;
      for (int j = 0; j < 3; j++) begin
        sum = sum + operand(w[4*(3*r+j) +: 4], int2) * operand(x[4*j +: 4], int2);
      end
      y[16*r +: 16] = sum[15:0];
    end
    return y;
  endfunction

  always @(posedge clk) begin
    if (!aresetn) begin
      in_q.delete();
      run_open    = 1'b0;
      first_cycle = 1'b1;
      prev_done   = 1'b0;
      prev_cont   = 1'b0;
      prev_en     = 1'b0;
      out_cnt     = 0;
      csr_idx     = 0;
      idle_exp    = 1'b1;
      ready_exp   = 1'b0;
    end else begin
      if (first_cycle && (!cs_idle_o || state_o != S_IDLE || cs_ready_o || cs_done_o ||
          csr_ce_o || wm_ce_o || infifo_read_o || outfifo_write_o)) begin
        $display("** Error after reset: cs_idle_o=%h state_o=%h strobes=%h", cs_idle_o,
                 state_o, {cs_ready_o, cs_done_o, csr_ce_o, wm_ce_o, infifo_read_o,
                 outfifo_write_o});
        ctrl_errs = ctrl_errs + 1;
      end
      first_cycle = 1'b0;
      // Start is taken only from idle with enable high
      ready_exp = idle_exp && cs_start_i && enable_i;
      if (cs_idle_o !== idle_exp || (state_o == S_IDLE) !== idle_exp) begin
        $display("** Error cs_idle_o: got %h with state_o=%h, expected %h", cs_idle_o,
                 state_o, idle_exp);
        ctrl_errs = ctrl_errs + 1;
      end
      if (cs_ready_o !== ready_exp) begin
        $display("** Error cs_ready_o: got %h, expected %h", cs_ready_o, ready_exp);
        ctrl_errs = ctrl_errs + 1;
      end
      // Accepted start opens a run
      if (cs_ready_o) begin
        if (run_open || !cs_idle_o) begin
          $display("Ready pulsed outside idle or twice in one run");
          ctrl_errs = ctrl_errs + 1;
        end
        run_open = 1'b1;
        out_cnt  = 0;
        csr_idx  = 0;
        starts   = starts + 1;
      end
      if (csr_ce_o) begin
        if (csr_address_o !== addr_t'(csr_idx)) begin
          $display("** Error csr_address_o: got %h, expected %h", csr_address_o, csr_idx);
          ctrl_errs = ctrl_errs + 1;
        end
        csr_idx = csr_idx + 1;
      end
      if (wm_ce_o && wm_address_o !== addr_t'(exp_waddr_i)) begin
        $display("** Error wm_address_o: got %h, expected %h", wm_address_o, exp_waddr_i);
        ctrl_errs = ctrl_errs + 1;
      end
      if (infifo_read_o) begin
        if (infifo_is_empty_i) begin
          $display("Input FIFO read while it was empty");
          ctrl_errs = ctrl_errs + 1;
        end
        // One vector in flight at most
        if (in_q.size() != 0) begin
          $display("Input word read before the previous result was written");
          ctrl_errs = ctrl_errs + 1;
        end
        in_q.push_back(infifo_dout_i);
      end
      if (outfifo_write_o) begin
        if (outfifo_is_full_i) begin
          $display("Output FIFO written while it was full");
          ctrl_errs = ctrl_errs + 1;
        end
        if (in_q.size() == 0) begin
          $display("Result written with no input word outstanding");
          ctrl_errs = ctrl_errs + 1;
        end else begin
          x_word = in_q.pop_front();
          y_exp  = predict(exp_prec_i == 8'd1, exp_weight_i, x_word);
          if (outfifo_din_o !== y_exp) begin
            $display("** Error outfifo_din_o: got %h, expected %h (x %h)", outfifo_din_o,
                     y_exp, x_word);
            data_errs = data_errs + 1;
          end
        end
        out_cnt = out_cnt + 1;
      end
      // Done holds until continue lands with enable high
      if (prev_done && !(prev_cont && prev_en) && !cs_done_o) begin
        $display("Done dropped before continue");
        ctrl_errs = ctrl_errs + 1;
      end
      if (prev_done && prev_cont && prev_en && !cs_idle_o) begin
        $display("Idle did not return after continue");
        ctrl_errs = ctrl_errs + 1;
      end
      if (cs_done_o && !prev_done) begin
        if (out_cnt != int'(exp_count_i)) begin
          $display("** Error output count: got %h, expected %h", out_cnt, exp_count_i);
          data_errs = data_errs + 1;
        end
        if (!run_open || in_q.size() != 0) begin
          $display("Done without a start or with an input word unanswered");
          ctrl_errs = ctrl_errs + 1;
        end
        run_open = 1'b0;
        runs     = runs + 1;
      end
      // Idle for the next cycle
      if (ready_exp) begin
        idle_exp = 1'b0;
      end else if (cs_done_o && cs_continue_i && enable_i) begin
        idle_exp = 1'b1;
      end
      prev_done = cs_done_o;
      prev_cont = cs_continue_i;
      prev_en   = enable_i;
    end
  end

endmodule

`default_nettype wire

// ==== tb_dtpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dtpu_core;
  import dtpu_pkg::*;

  localparam int NROWS    = 5;
  localparam int CLK_HALF = 20;

  // One run: CSR bytes, weight word, back-pressure mode
  typedef struct packed {
    logic [7:0]  prec;
    logic [7:0]  count;
    logic [7:0]  waddr;
    logic [63:0] weight;
    logic        stall;
  } row_t;

  // Vector count doubles as the expected number of outputs
  localparam row_t ROWS [NROWS] = '{
    '{8'h00, 8'd4, 8'h10, 64'hDEAD_000F_8A71_23C9, 1'b0},
    '{8'h01, 8'd4, 8'h25, 64'h0000_0003_2103_1E2D, 1'b0},
    '{8'h00, 8'd0, 8'h03, 64'h0000_0001_2345_6789, 1'b0},
    '{8'h07, 8'd6, 8'hC4, 64'h0000_0008_7F80_9EA1, 1'b1},
    '{8'h01, 8'd5, 8'hFE, 64'hFFFF_FFFA_B6E5_D4C3, 1'b1}
  };

  logic      clk;
  logic      aresetn;
  logic      enable;
  logic      csr_ce;
  addr_t     csr_address;
  csr_byte_t csr_dout;
  logic      wm_ce;
  addr_t     wm_address;
  word_t     wm_dout;
  logic      infifo_is_empty;
  word_t     infifo_dout;
  logic      infifo_read;
  logic      outfifo_is_full;
  word_t     outfifo_din;
  logic      outfifo_write;
  logic      cs_start;
  logic      cs_continue;
  logic      cs_ready;
  logic      cs_done;
  logic      cs_idle;
  cu_state_t state;

  // Memory models and input FIFO contents
  csr_byte_t csr_mem [256];
  word_t     wm_mem [256];
  word_t     in_q [$];
  // Requests seen at the clock edge, answered half a cycle later
  logic       csr_pend;
  logic [7:0] csr_pend_addr;
  logic       wm_pend;
  logic [7:0] wm_pend_addr;
  logic       rd_taken;

  // Expected configuration handed to the checker
  logic [7:0] exp_prec;
  logic [7:0] exp_count;
  logic [7:0] exp_waddr;
  word_t      exp_weight;

  logic stall_mode;
  int   seed;
  int   rnd;
  int   hold_cnt;
  int   cycles;
  int   limit;
  int   tb_errs;
  int   data_errs;
  int   ctrl_errs;
  int   runs;
  int   starts;

  dtpu_core i_dut (
    .clk               (clk),
    .aresetn           (aresetn),
    .enable_i          (enable),
    .csr_ce_o          (csr_ce),
    .csr_address_o     (csr_address),
    .csr_dout_i        (csr_dout),
    .wm_ce_o           (wm_ce),
    .wm_address_o      (wm_address),
    .wm_dout_i         (wm_dout),
    .infifo_is_empty_i (infifo_is_empty),
    .infifo_dout_i     (infifo_dout),
    .infifo_read_o     (infifo_read),
    .outfifo_is_full_i (outfifo_is_full),
    .outfifo_din_o     (outfifo_din),
    .outfifo_write_o   (outfifo_write),
    .cs_start_i        (cs_start),
    .cs_continue_i     (cs_continue),
    .cs_ready_o        (cs_ready),
    .cs_done_o         (cs_done),
    .cs_idle_o         (cs_idle),
    .state_o           (state)
  );

  dtpu_checker i_chk (
    .clk               (clk),
    .aresetn           (aresetn),
    .enable_i          (enable),
    .csr_ce_o          (csr_ce),
    .csr_address_o     (csr_address),
    .wm_ce_o           (wm_ce),
    .wm_address_o      (wm_address),
    .infifo_is_empty_i (infifo_is_empty),
    .infifo_dout_i     (infifo_dout),
    .infifo_read_o     (infifo_read),
    .outfifo_is_full_i (outfifo_is_full),
    .outfifo_din_o     (outfifo_din),
    .outfifo_write_o   (outfifo_write),
    .cs_start_i        (cs_start),
    .cs_continue_i     (cs_continue),
    .cs_ready_o        (cs_ready),
    .cs_done_o         (cs_done),
    .cs_idle_o         (cs_idle),
    .state_o           (state),
    .exp_prec_i        (exp_prec),
    .exp_count_i       (exp_count),
    .exp_waddr_i       (exp_waddr),
    .exp_weight_i      (exp_weight),
    .data_errs_o       (data_errs),
    .ctrl_errs_o       (ctrl_errs),
    .runs_o            (runs),
    .starts_o          (starts)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Memory, FIFO and back-pressure models
  ////////////////////////////////////////////////////////////////////////////

  // Strobes sampled before the edge updates the DUT
  always @(posedge clk) begin
    csr_pend      <= csr_ce;
    csr_pend_addr <= csr_address[7:0];
    wm_pend       <= wm_ce;
    wm_pend_addr  <= wm_address[7:0];
    rd_taken      <= infifo_read;
  end

  always @(negedge clk) begin
    rnd = $random(seed);
    // Read data one cycle after ce
    if (csr_pend) begin
      csr_dout = csr_mem[csr_pend_addr];
    end
    if (wm_pend) begin
      wm_dout = wm_mem[wm_pend_addr];
    end
    if (rd_taken && in_q.size() != 0) begin
      void'(in_q.pop_front());
    end
    // FWFT head, random gaps on stall rows
    infifo_is_empty = (in_q.size() == 0) || (stall_mode && rnd[0]);
    infifo_dout     = (in_q.size() != 0) ? in_q[0] : '0;
    outfifo_is_full = stall_mode && rnd[1];
    // Enable holds only while vectors are in flight
    if (hold_cnt != 0) begin
      hold_cnt = hold_cnt - 1;
    end else if (stall_mode && (state inside {S_READ, S_CALC, S_WRITE}) &&
                 rnd[6:3] == 4'd0) begin
      hold_cnt = 3 + int'(rnd[8:7]);
    end
    enable = (hold_cnt == 0);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input row_t row);
    word_t w;
    int    v;
    @(negedge clk);
    csr_mem[0]        = row.prec;
    csr_mem[1]        = row.count;
    csr_mem[2]        = row.waddr;
    wm_mem[row.waddr] = row.weight;
    exp_prec          = row.prec;
    exp_count         = row.count;
    exp_waddr         = row.waddr;
    exp_weight        = row.weight;
    stall_mode        = row.stall;
    for (v = 0; v < int'(row.count); v++) begin
      w = {$random(seed), $random(seed)};
      in_q.push_back(w);
    end
    cs_start = 1'b1;
    do @(posedge clk); while (!cs_ready);
    @(negedge clk);
    cs_start = 1'b0;
    do @(posedge clk); while (!cs_done);
    @(negedge clk);
    cs_continue = 1'b1;
    // Continue may sit through an enable hold
    do @(posedge clk); while (!cs_idle);
    @(negedge clk);
    cs_continue = 1'b0;
  endtask

  task automatic report_and_finish(input bit timed_out);
    int total;
    total = data_errs + ctrl_errs + tb_errs;
    $display("Errors: data %0d, control %0d, testbench %0d", data_errs, ctrl_errs, tb_errs);
    if (timed_out || total != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  endtask

  // Cycle budget from the table
  always @(posedge clk) begin
    if (aresetn) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("Timeout: run did not finish within %0d cycles", limit);
        report_and_finish(1'b1);
      end
    end
  end

  initial begin
    seed            = 6;
    aresetn         = 1'b0;
    enable          = 1'b1;
    csr_dout        = '0;
    wm_dout         = '0;
    infifo_is_empty = 1'b1;
    infifo_dout     = '0;
    outfifo_is_full = 1'b0;
    cs_start        = 1'b0;
    cs_continue     = 1'b0;
    csr_pend        = 1'b0;
    wm_pend         = 1'b0;
    rd_taken        = 1'b0;
    stall_mode      = 1'b0;
    hold_cnt        = 0;
    cycles          = 0;
    tb_errs         = 0;
    exp_prec        = '0;
    exp_count       = '0;
    exp_waddr       = '0;
    exp_weight      = '0;
    limit           = 50 * NROWS;
    for (int i = 0; i < NROWS; i++) begin
      limit = limit + 20 * int'(ROWS[i].count);
    end
    // Fill from the whole address so a wrong read shows
    for (int a = 0; a < 256; a++) begin
      csr_mem[a] = csr_byte_t'(a) ^ 8'h5A;
      wm_mem[a]  = {8{csr_byte_t'(a) ^ 8'hA5}};
    end
    repeat (4) @(negedge clk);
    aresetn = 1'b1;
    for (int i = 0; i < NROWS; i++) begin
      run_row(ROWS[i]);
    end
    repeat (2) @(negedge clk);
    if (runs != NROWS || starts != NROWS) begin
      $display("Run count wrong: %0d starts and %0d done for %0d table rows",
               starts, runs, NROWS);
      tb_errs = tb_errs + 1;
    end
    report_and_finish(1'b0);
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
dtpu_pkg.sv
dtpu_ifs.sv
csr_regs.sv
control_unit.sv
mac_cell.sv
mxu_array.sv
dtpu_core.sv
dtpu_checker.sv
tb_dtpu_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_dtpu_core -o tb_dtpu_core

./obj_dir/tb_dtpu_core | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi
